//--- rtl/laneDefs.sv
//////////////////////////////////////////////////
// Shared command codes, register ids and packet
// types of the secondary execute lane.
// Imported by the lane modules and the testbench
//////////////////////////////////////////////////

package laneDefs;

	// Micro-op command, as issued by decode
	typedef enum logic [3:0] {
		NOP   = 4'h0, // No writeback at all
		ALU3  = 4'h1, // Rn = Rs op Rt, op picked by ixt
		MULW3 = 4'h2, // Low word multiply
		IXT   = 4'h3  // Extended ops, sub-op in ixt
	} uCmdT;

	// Sub-op codes, ALU functions and keyring ops
	typedef enum logic [3:0] {
		ADD   = 4'h0,
		SUB   = 4'h1,
		AND   = 4'h2,
		OR    = 4'h3,
		XOR   = 4'h4,
		KRMIX = 4'h5  // Rs ^ rotl(Rt, imm[5:0]), lands in DHR
	} ixtCmdT;

	typedef logic [5:0] regIdT; // GPR id

	localparam regIdT regZzr = 6'd0; // Zero register, writes discarded
	localparam regIdT regDhr = 6'd1; // Keyring destination

	// Issue packet into EX1
	typedef struct packed {
		uCmdT        cmd;
		ixtCmdT      ixt;
		regIdT       regIdRn; // Destination
		logic [63:0] rs;      // Source A value
		logic [63:0] rt;      // Source B value
		logic [32:0] imm;     // Immediate from decode
	} issuePktT;

	// Writeback record toward the register file
	typedef struct packed {
		regIdT       regId;
		logic [63:0] value;
	} wbPktT;

endpackage

//--- rtl/laneIf.sv
//////////////////////////////////////////////////
// Stage to stage link of the execute lane.
// Valid/ready handshake plus one op and its values
//////////////////////////////////////////////////
`timescale 1ns/1ns

interface laneIf
	import laneDefs::*;
();
	logic        valid;   // Op present
	logic        ready;   // Downstream takes it this cycle
	uCmdT        cmd;
	ixtCmdT      ixt;
	regIdT       regIdRn; // Destination id
	logic [63:0] valA;    // Rs value
	logic [63:0] valB;    // Rt value
	logic [32:0] imm;
	logic [63:0] result;  // Result so far
	logic        flushed; // Op killed by a branch flush

	// Upstream stage
	modport src(output valid, cmd, ixt, regIdRn, valA, valB, imm, result, flushed,
		input ready);

	// Downstream stage
	modport snk(input valid, cmd, ixt, regIdRn, valA, valB, imm, result, flushed,
		output ready);

endinterface

//--- rtl/stageBuffer.sv
//////////////////////////////////////////////////
// Small circular FIFO with valid/ready on both
// sides. Payload type set by the instantiating
// module, used on the lane's input and output
//////////////////////////////////////////////////
`timescale 1ns/1ns

module stageBuffer #(
	parameter int  bufDepth = 2,
	parameter type entryT   = logic [63:0]
) (
	input  logic  clock,
	input  logic  rstN,
	input  logic  inValid,
	output logic  inReady,
	input  entryT inData,
	output logic  outValid,
	input  logic  outReady,
	output entryT outData
);
	localparam int ptrW = (bufDepth > 1) ? $clog2(bufDepth) : 1;
	localparam int cntW = $clog2(bufDepth + 1);

	entryT           mem [bufDepth]; // Payload storage
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] fillCount;      // Entries held
	logic            isFull;
	logic            push;
	logic            pop;

	// Wrap at bufDepth, depth need not be a power of two
	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
		nextPtr = (ptr == ptrW'(bufDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign isFull   = (fillCount == cntW'(bufDepth));
	assign outValid = (fillCount != '0);
	assign outData  = mem[rdPtr];           // Head entry
	assign inReady  = !isFull || outReady;  // Full but draining still accepts
	assign push     = inValid && inReady;
	assign pop      = outValid && outReady;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fillCount <= '0;
		end else begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10:   fillCount <= fillCount + 1'b1;
				2'b01:   fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount; // Idle, or in and out together
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wrPtr] <= inData;
	end

endmodule

//--- rtl/exStage1.sv
//////////////////////////////////////////////////
// EX1 of the secondary lane. Takes issue packets
// from the input buffer and does the ALU3 ops
//////////////////////////////////////////////////
`timescale 1ns/1ns

module exStage1
	import laneDefs::*;
(
	input  logic     clock,
	input  logic     rstN,
	input  logic     braFlush,
	input  logic     inValid,
	output logic     inReady,
	input  issuePktT inPkt,
	laneIf.src       ex12
);
	logic        slotValid;   // Slot holds an op
	logic        slotFlushed;
	issuePktT    slotPkt;
	logic [63:0] slotResult;
	logic [63:0] aluResult;   // ALU output for the incoming op

	// Slot frees up when empty or when EX2 takes it
	assign inReady = !slotValid || ex12.ready;

	always_comb begin
		aluResult = '0; // Non-ALU ops carry zero
		if (inPkt.cmd == ALU3) begin
			case (inPkt.ixt)
				ADD:     aluResult = inPkt.rs + inPkt.rt;
				SUB:     aluResult = inPkt.rs - inPkt.rt;
				AND:     aluResult = inPkt.rs & inPkt.rt;
				OR:      aluResult = inPkt.rs | inPkt.rt;
				XOR:     aluResult = inPkt.rs ^ inPkt.rt;
				default: aluResult = '0;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			slotValid   <= 1'b0;
			slotFlushed <= 1'b0;
		end else if (inReady) begin
			slotValid   <= inValid;
			slotFlushed <= 1'b0;       // Buffered ops escape the flush
		end else if (braFlush) begin
			slotFlushed <= 1'b1;       // Stalled op gets killed
		end
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady) begin
			slotPkt    <= inPkt;
			slotResult <= aluResult;
		end
	end

	assign ex12.valid   = slotValid;
	assign ex12.cmd     = slotPkt.cmd;
	assign ex12.ixt     = slotPkt.ixt;
	assign ex12.regIdRn = slotPkt.regIdRn;
	assign ex12.valA    = slotPkt.rs;
	assign ex12.valB    = slotPkt.rt;
	assign ex12.imm     = slotPkt.imm;
	assign ex12.result  = slotResult;
	assign ex12.flushed = slotFlushed;

endmodule

//--- rtl/exStage2.sv
//////////////////////////////////////////////////
// EX2 of the secondary lane. MUL.W low product and
// keyring mix, other results pass through from EX1
//////////////////////////////////////////////////
`timescale 1ns/1ns

module exStage2
	import laneDefs::*;
(
	input  logic clock,
	input  logic rstN,
	input  logic braFlush,
	laneIf.snk   ex12,
	laneIf.src   ex23
);
	logic               slotValid;
	logic               slotFlushed;
	uCmdT               slotCmd;
	ixtCmdT             slotIxt;
	regIdT              slotRegId;
	logic [63:0]        slotValA;
	logic [63:0]        slotValB;
	logic [32:0]        slotImm;
	logic [63:0]        slotResult;
	logic signed [63:0] mulProd;   // Full 32x32 signed product
	logic [127:0]       rotWide;   // Rt doubled then shifted, top half is the rotate
	logic [63:0]        nextResult;

	assign ex12.ready = !slotValid || ex23.ready;

	assign mulProd = $signed(ex12.valA[31:0]) * $signed(ex12.valB[31:0]);
	assign rotWide = {ex12.valB, ex12.valB} << ex12.imm[5:0];

	always_comb begin
		nextResult = ex12.result; // EX1 result by default
		if (ex12.cmd == MULW3)
			nextResult = {{32{mulProd[31]}}, mulProd[31:0]}; // Low word, sign extended
		else if (ex12.cmd == IXT && ex12.ixt == KRMIX)
			nextResult = ex12.valA ^ rotWide[127:64];
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			slotValid   <= 1'b0;
			slotFlushed <= 1'b0;
		end else if (ex12.ready) begin
			slotValid   <= ex12.valid;
			slotFlushed <= ex12.flushed || braFlush; // Op was in EX1 during the flush
		end else if (braFlush) begin
			slotFlushed <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (ex12.valid && ex12.ready) begin
			slotCmd    <= ex12.cmd;
			slotIxt    <= ex12.ixt;
			slotRegId  <= ex12.regIdRn;
			slotValA   <= ex12.valA;
			slotValB   <= ex12.valB;
			slotImm    <= ex12.imm;
			slotResult <= nextResult;
		end
	end

	assign ex23.valid   = slotValid;
	assign ex23.cmd     = slotCmd;
	assign ex23.ixt     = slotIxt;
	assign ex23.regIdRn = slotRegId;
	assign ex23.valA    = slotValA;
	assign ex23.valB    = slotValB;
	assign ex23.imm     = slotImm;
	assign ex23.result  = slotResult;
	assign ex23.flushed = slotFlushed;

endmodule

//--- rtl/exStage3.sv
//////////////////////////////////////////////////
// EX3 of the secondary lane. Picks the final
// destination and value, retires dead records here
//////////////////////////////////////////////////
`timescale 1ns/1ns

module exStage3
	import laneDefs::*;
(
	input  logic  clock,
	input  logic  rstN,
	input  logic  braFlush,
	laneIf.snk    ex23,
	output logic  outValid,
	input  logic  outReady,
	output wbPktT outPkt
);
	logic  slotValid;
	logic  slotFlushed;
	logic  slotNop;     // No writeback for this op
	wbPktT slotPkt;     // Destination already resolved for keyring ops
	regIdT inDest;      // Destination of the incoming op
	logic  drop;        // Slot content is retired without output

	// Forward by default, keyring mix always lands in DHR
	assign inDest = (ex23.cmd == IXT && ex23.ixt == KRMIX) ? regDhr : ex23.regIdRn;

	// Flushed or flushing ops go to the zero register
	assign outPkt.regId = (slotFlushed || braFlush) ? regZzr : slotPkt.regId;
	assign outPkt.value = slotPkt.value;

	assign drop     = slotNop || (outPkt.regId == regZzr);
	assign outValid = slotValid && !drop;

	// Dropped records free the slot on their own
	assign ex23.ready = !slotValid || drop || outReady;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			slotValid   <= 1'b0;
			slotFlushed <= 1'b0;
		end else if (ex23.ready) begin
			slotValid   <= ex23.valid;
			slotFlushed <= ex23.flushed || braFlush;
		end else if (braFlush) begin
			slotFlushed <= 1'b1; // Blocked record is killed
		end
	end

	always_ff @(posedge clock) begin
		if (ex23.valid && ex23.ready) begin
			slotNop       <= (ex23.cmd == NOP);
			slotPkt.regId <= inDest;
			slotPkt.value <= ex23.result;
		end
	end

endmodule

//--- rtl/exLaneTop.sv
//////////////////////////////////////////////////
// Top of the secondary execute lane. Issue ports
// in, writeback records out, flush as a level input
//////////////////////////////////////////////////
`timescale 1ns/1ns

module exLaneTop
	import laneDefs::*;
#(
	parameter int bufDepth = 2
) (
	input  logic        clock,
	input  logic        rstN,
	input  logic        inValid,
	output logic        inReady,
	input  uCmdT        inCmd,
	input  ixtCmdT      inIxt,
	input  regIdT       inRegIdRn,
	input  logic [63:0] inRs,
	input  logic [63:0] inRt,
	input  logic [32:0] inImm,
	input  logic        braFlush,
	output logic        outValid,
	input  logic        outReady,
	output regIdT       outRegId,
	output logic [63:0] outValue
);
	issuePktT issuePkt;  // Issue ports packed
	issuePktT bufPkt;    // Input buffer head
	logic     bufValid;
	logic     bufReady;
	wbPktT    ex3Pkt;    // Record from EX3
	logic     ex3Valid;
	logic     ex3Ready;
	wbPktT    retirePkt; // Output buffer head

	laneIf ex12();
	laneIf ex23();

	assign issuePkt = '{cmd: inCmd, ixt: inIxt, regIdRn: inRegIdRn,
		rs: inRs, rt: inRt, imm: inImm};

	stageBuffer #(.bufDepth(bufDepth), .entryT(issuePktT)) issueBuf (
		.clock(clock), .rstN(rstN),
		.inValid(inValid), .inReady(inReady), .inData(issuePkt),
		.outValid(bufValid), .outReady(bufReady), .outData(bufPkt));

	exStage1 ex1 (.clock(clock), .rstN(rstN), .braFlush(braFlush),
		.inValid(bufValid), .inReady(bufReady), .inPkt(bufPkt), .ex12(ex12));

	exStage2 ex2 (.clock(clock), .rstN(rstN), .braFlush(braFlush),
		.ex12(ex12), .ex23(ex23));

	exStage3 ex3 (.clock(clock), .rstN(rstN), .braFlush(braFlush), .ex23(ex23),
		.outValid(ex3Valid), .outReady(ex3Ready), .outPkt(ex3Pkt));

	stageBuffer #(.bufDepth(bufDepth), .entryT(wbPktT)) retireBuf (
		.clock(clock), .rstN(rstN),
		.inValid(ex3Valid), .inReady(ex3Ready), .inData(ex3Pkt),
		.outValid(outValid), .outReady(outReady), .outData(retirePkt));

	assign outRegId = retirePkt.regId;
	assign outValue = retirePkt.value;

endmodule

//--- test/exLane_asserts.sv
//////////////////////////////////////////////////
// Concurrent checks on the lane handshakes and
// the flush rules, bound into exLaneTop
//////////////////////////////////////////////////
`timescale 1ns/1ns

module exLane_asserts
	import laneDefs::*;
#(
	parameter int bufDepth = 2
) (
	input logic        clock,
	input logic        rstN,
	input logic        inValid,
	input logic        inReady,
	input logic        bufValid,   // Input buffer head valid
	input logic        bufReady,   // EX1 takes the head
	input logic        ex12Valid,
	input logic        ex23Valid,
	input logic        ex3Valid,
	input logic        outValid,
	input logic        outReady,
	input regIdT       outRegId,
	input logic [63:0] outValue
);
	logic resetSeen; // Reset low on the previous edge too
	int   issueFill; // Input buffer entries, counted from its two handshakes

	always_ff @(posedge clock)
		resetSeen <= !rstN;

	always_ff @(posedge clock) begin
		if (!rstN)
			issueFill <= 0;
		else
			issueFill <= issueFill + int'(inValid && inReady) - int'(bufValid && bufReady);
	end

	// Registers are cleared after the first reset edge
	noValidInReset: assert property (@(posedge clock) (!rstN && resetSeen)
		|-> !(bufValid || ex12Valid || ex23Valid || ex3Valid || outValid))
		else $error("Valid signal high while reset is applied");

	outputHeld: assert property (@(posedge clock) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outRegId) && $stable(outValue)))
		else $error("Output record changed while outReady was low");

	noZzrOutput: assert property (@(posedge clock) disable iff (!rstN)
		outValid |-> (outRegId != regZzr))
		else $error("Write to the zero register reached the output");

	readyWhenRoom: assert property (@(posedge clock) disable iff (!rstN)
		(issueFill < bufDepth) |-> inReady)
		else $error("Input side not ready although the input buffer has room");

endmodule

bind exLaneTop exLane_asserts #(.bufDepth(bufDepth)) chk0 (
	.clock(clock), .rstN(rstN), .inValid(inValid), .inReady(inReady),
	.bufValid(bufValid), .bufReady(bufReady), .ex12Valid(ex12.valid),
	.ex23Valid(ex23.valid), .ex3Valid(ex3Valid), .outValid(outValid),
	.outReady(outReady), .outRegId(outRegId), .outValue(outValue));

//--- test/exLaneTb.sv
//////////////////////////////////////////////////
// Directed testbench of the execute lane. Issues
// ops, predicts writeback records and compares
// them in order at the output handshake
//////////////////////////////////////////////////
`timescale 1ns/1ns

module exLaneTb
	import laneDefs::*;
();
	localparam int totalOps = 20 + 10 + 12 + 40 + 13; // Ops issued by all tests

	typedef struct packed {
		wbPktT rec;
		logic  mayDrop; // Issued before a flush, may never show up
	} expEntryT;

	logic        clock = 1'b0;
	logic        rstN;
	logic        inValid;
	logic        inReady;
	uCmdT        inCmd;
	ixtCmdT      inIxt;
	regIdT       inRegIdRn;
	logic [63:0] inRs;
	logic [63:0] inRt;
	logic [32:0] inImm;
	logic        braFlush;
	logic        outValid;
	logic        outReady;
	regIdT       outRegId;
	logic [63:0] outValue;
	expEntryT    expQ [$];       // Records still expected, issue order
	int          mismatchCount = 0;
	int          otherCount = 0;
	int          skipCount = 0;  // Pre-flush records that never came out
	logic        issueDone;

	exLaneTop #(.bufDepth(2)) dut0 (.*);

	always #20 clock = ~clock; // 40 ns period

	// Writeback record predicted from the op, returns 0 when nothing is written
	function automatic logic expectRecord(input uCmdT cmd, input ixtCmdT ixt,
		input regIdT rn, input logic [63:0] rs, input logic [63:0] rt,
		input logic [32:0] imm, output wbPktT rec);
		logic [63:0] rotated;
		longint      prod;
		rotated = (imm[5:0] == 6'd0) ? rt : ((rt << imm[5:0]) | (rt >> (7'd64 - imm[5:0])));
		prod = longint'($signed(rs[31:0])) * longint'($signed(rt[31:0]));
		rec.regId = rn;
		rec.value = '0;
		case (cmd)
			ALU3: begin
				case (ixt)
					ADD:     rec.value = rs + rt;
					SUB:     rec.value = rs - rt;
					AND:     rec.value = rs & rt;
					OR:      rec.value = rs | rt;
					XOR:     rec.value = rs ^ rt;
					default: rec.value = '0;
				endcase
			end
			MULW3: rec.value = {{32{prod[31]}}, prod[31:0]}; // Low word only
			IXT: if (ixt == KRMIX) begin
				rec.regId = regDhr; // Keyring result ignores the destination field
				rec.value = rs ^ rotated;
			end
			default: ;
		endcase
		return (cmd != NOP) && (rec.regId != regZzr);
	endfunction

	// Starts at 2 ns past an edge, returns 2 ns past the accepting edge
	task automatic issueOp(input uCmdT cmd, input ixtCmdT ixt, input regIdT rn,
		input logic [63:0] rs, input logic [63:0] rt, input logic [32:0] imm,
		input logic mayDrop);
		wbPktT rec;
		logic  taken;
		if (expectRecord(cmd, ixt, rn, rs, rt, imm, rec))
			expQ.push_back('{rec: rec, mayDrop: mayDrop});
		inCmd = cmd;
		inIxt = ixt;
		inRegIdRn = rn;
		inRs = rs;
		inRt = rt;
		inImm = imm;
		inValid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clock);
			taken = inReady; // Stable until the next edge
			@(posedge clock);
			#2;
		end
		inValid = 1'b0;
	endtask

	task automatic issueRandomAlu(input logic mayDrop);
		issueOp(ALU3, ixtCmdT'($urandom_range(0, 4)), regIdT'($urandom_range(2, 63)),
			{$urandom, $urandom}, {$urandom, $urandom}, {1'b0, $urandom}, mayDrop);
	endtask

	task automatic issueRandomOp();
		int pick;
		pick = $urandom_range(0, 7);
		if (pick == 0)
			issueOp(NOP, ADD, regIdT'($urandom_range(0, 63)), {$urandom, $urandom},
				{$urandom, $urandom}, '0, 1'b0);
		else if (pick <= 4)
			issueOp(ALU3, ixtCmdT'($urandom_range(0, 4)), regIdT'($urandom_range(0, 63)),
				{$urandom, $urandom}, {$urandom, $urandom}, '0, 1'b0);
		else if (pick <= 6)
			issueOp(MULW3, ADD, regIdT'($urandom_range(0, 63)), {$urandom, $urandom},
				{$urandom, $urandom}, '0, 1'b0);
		else
			issueOp(IXT, KRMIX, regIdT'($urandom_range(0, 63)), {$urandom, $urandom},
				{$urandom, $urandom}, {1'b0, $urandom}, 1'b0);
	endtask

	task automatic drainOutputs();
		while (expQ.size() != 0)
			@(posedge clock);
		repeat (8) @(posedge clock); // Room for stray extra records
		#2;
	endtask

	task automatic testAlu();
		issueOp(ALU3, ADD, 6'd2, 64'hffff_ffff_ffff_ffff, 64'd2, '0, 1'b0); // Wraps
		issueOp(ALU3, SUB, 6'd3, 64'd0, 64'd1, '0, 1'b0);
		issueOp(ALU3, AND, 6'd4, 64'hf0f0_1234_5678_0f0f, 64'hff00_ff00_ff00_ff00, '0, 1'b0);
		issueOp(ALU3, OR, 6'd1, 64'h8000_0000_0000_0000, 64'h1, '0, 1'b0);
		issueOp(ALU3, XOR, 6'd63, 64'haaaa_5555_aaaa_5555, 64'hffff_ffff_0000_0000, '0, 1'b0);
		repeat (15) issueRandomAlu(1'b0);
		drainOutputs();
	endtask

	task automatic testMulw();
		issueOp(MULW3, ADD, 6'd5, 64'h1234_5678_ffff_fffd, 64'hffff_ffff_ffff_fffb, '0, 1'b0);
		issueOp(MULW3, ADD, 6'd6, 64'h7fff_ffff, 64'h7fff_ffff, '0, 1'b0); // Low word is 1
		issueOp(MULW3, ADD, 6'd7, 64'h8000_0000, 64'h8000_0000, '0, 1'b0);
		issueOp(MULW3, ADD, 6'd8, 64'hffff_ffff, 64'h7fff_ffff, '0, 1'b0); // Negative result
		repeat (6)
			issueOp(MULW3, ADD, regIdT'($urandom_range(1, 63)), {$urandom, $urandom},
				{$urandom, $urandom}, '0, 1'b0);
		drainOutputs();
	endtask

	task automatic testKeyMix();
		issueOp(IXT, KRMIX, 6'd0, 64'h0123_4567_89ab_cdef, 64'h8000_0000_0000_0001, 33'd0, 1'b0);
		issueOp(IXT, KRMIX, 6'd5, 64'h0, 64'h8000_0000_0000_0001, 33'd1, 1'b0);
		issueOp(IXT, KRMIX, 6'd1, 64'hffff, 64'hdead_beef_cafe_f00d, 33'd63, 1'b0);
		issueOp(IXT, KRMIX, 6'd40, 64'h5a5a, 64'h1111_2222_3333_4444, 33'h1_0000_0060, 1'b0);
		issueOp(NOP, ADD, 6'd7, 64'd1, 64'd2, '0, 1'b0);                  // Never written
		issueOp(ALU3, ADD, regZzr, 64'd3, 64'd4, '0, 1'b0);                // Dropped in EX3
		issueOp(MULW3, ADD, regZzr, 64'd5, 64'd6, '0, 1'b0);
		repeat (5)
			issueOp(IXT, KRMIX, regIdT'($urandom_range(0, 63)), {$urandom, $urandom},
				{$urandom, $urandom}, {1'b0, $urandom}, 1'b0);
		drainOutputs();
	endtask

	task automatic testBackPressure();
		outReady = 1'b0;
		repeat (7) issueRandomAlu(1'b0); // Fills buffers and stages
		repeat (4) @(posedge clock);
		@(negedge clock);
		assert (!inReady) else begin
			otherCount++;
			$display("Input side still ready at %0t with the output blocked", $time);
		end
		@(posedge clock);
		#2;
		issueDone = 1'b0;
		fork
			begin
				repeat (33) issueRandomOp();
				issueDone = 1'b1;
			end
			begin
				while (!issueDone) begin
					outReady = $urandom_range(0, 1); // Random stalls
					@(posedge clock);
					#2;
				end
				outReady = 1'b1;
			end
		join
		drainOutputs();
	endtask

	task automatic testFlush();
		skipCount = 0;
		outReady = 1'b0;
		repeat (7) issueRandomAlu(1'b1);
		repeat (8) @(posedge clock); // Let every stage fill up
		#2;
		braFlush = 1'b1;
		@(posedge clock);
		#2;
		braFlush = 1'b0;
		outReady = 1'b1;
		repeat (6) issueRandomAlu(1'b0);
		drainOutputs();
		assert (skipCount > 0) else begin
			otherCount++;
			$display("Flush at %0t removed none of the ops held in EX1 to EX3", $time);
		end
	endtask

	// Output transfers are judged at the falling edge, before they complete
	always @(negedge clock) begin : monitor
		expEntryT head;
		if (rstN && outValid && outReady) begin
			while (expQ.size() != 0 && expQ[0].mayDrop &&
				!(expQ[0].rec.regId == outRegId && expQ[0].rec.value == outValue)) begin
				head = expQ.pop_front(); // Flushed before it got out
				skipCount++;
			end
			assert (expQ.size() != 0) else begin
				otherCount++;
				$display("Unexpected output record r%0d=%h at %0t", outRegId, outValue, $time);
			end
			if (expQ.size() != 0) begin
				head = expQ.pop_front();
				assert (head.rec.regId == outRegId && head.rec.value == outValue) else begin
					mismatchCount++;
					$display("Mismatch at %0t: expected r%0d=%h, got r%0d=%h", $time,
						head.rec.regId, head.rec.value, outRegId, outValue);
				end
			end
		end
	end

	initial begin : watchdog
		#(40 * (totalOps * 8 + 2000));
		$display("Timeout at %0t, the tests did not finish", $time);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'h0d7c38d2));
		rstN = 1'b0;
		inValid = 1'b0;
		inCmd = NOP;
		inIxt = ADD;
		inRegIdRn = '0;
		inRs = '0;
		inRt = '0;
		inImm = '0;
		braFlush = 1'b0;
		outReady = 1'b1;
		issueDone = 1'b0;
		repeat (3) @(posedge clock);
		#2;
		rstN = 1'b1;
		@(posedge clock);
		#2;
		testAlu();
		testMulw();
		testKeyMix();
		testBackPressure();
		testFlush();
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- sim.f
rtl/laneDefs.sv
rtl/laneIf.sv
rtl/stageBuffer.sv
rtl/exStage1.sv
rtl/exStage2.sv
rtl/exStage3.sv
rtl/exLaneTop.sv
test/exLane_asserts.sv
test/exLaneTb.sv

//--- run.sh
#!/bin/sh
# Builds the lane testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module exLaneTb \
	--Mdir obj_dir -o exLaneSim || { echo "Build failed"; exit 1; }
# A run that stops early counts as a failure
./obj_dir/exLaneSim > sim.log 2>&1 || echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
